// ==== Bender.yml ====
package:
  name: spi_master

sources:
  - files:
      - rtl/spi_pkg.sv
      - rtl/spi_ctrl_if.sv
      - rtl/spi_fifo.sv
      - rtl/spi_reg_decode.sv
      - rtl/spi_controller.sv
      - rtl/spi_datapath.sv
      - rtl/spi_master_top.sv
  - target: simulation
    files:
      - verif/spi_master_assert.sv
      - verif/spi_master_tb.sv

// ==== build.f ====
rtl/spi_pkg.sv
rtl/spi_ctrl_if.sv
rtl/spi_fifo.sv
rtl/spi_reg_decode.sv
rtl/spi_controller.sv
rtl/spi_datapath.sv
rtl/spi_master_top.sv
verif/spi_master_assert.sv
verif/spi_master_tb.sv

// ==== rtl/spi_controller.sv ====
// --------------------------------------------------
// SPI frame sequencer, mode 0, one byte per frame
// Paces sclk and cs_n, issues per-bit strobes
// --------------------------------------------------
`timescale 1ns/1ps

module spi_controller (
    input  logic               clk,
    input  logic               rst_n,
    input  spi_pkg::spi_cfg_t  cfg_i,
    input  logic               tx_empty_i,
    output logic               busy_o,
    output logic               sclk_o,
    output logic               cs_n_o,
    spi_ctrl_if.ctrl           ctrl
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SHIFT
    } state_e;

    state_e     state_q;
    logic [3:0] div_cnt_q;
    // Counts falling edges, reaches 8 in the closing cycle
    logic [3:0] bit_cnt_q;
    logic       sclk_q;
    logic       cs_n_q;

    logic       half_end;
    logic       in_bits;
    logic       frame_end;
    logic       rise;
    logic       fall;

    assign half_end  = (div_cnt_q == cfg_i.clk_div);
    assign in_bits   = (state_q == ST_SHIFT) && !bit_cnt_q[3];
    assign frame_end = (state_q == ST_SHIFT) && bit_cnt_q[3];
    assign rise      = in_bits && !sclk_q && half_end;
    assign fall      = in_bits && sclk_q && half_end;

    // --------------------------------------------------
    // Sequencer
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
            sclk_q    <= 1'b0;
            cs_n_q    <= 1'b1;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (!tx_empty_i) begin
                        state_q <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    state_q   <= ST_SHIFT;
                    cs_n_q    <= 1'b0;
                    div_cnt_q <= '0;
                    bit_cnt_q <= '0;
                    sclk_q    <= 1'b0;
                end
                ST_SHIFT: begin
                    if (frame_end) begin
                        state_q <= ST_IDLE;
                        cs_n_q  <= 1'b1;
                    end else if (half_end) begin
                        div_cnt_q <= '0;
                        sclk_q    <= !sclk_q;
                        if (sclk_q) begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end else begin
                        div_cnt_q <= div_cnt_q + 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Strobes to the datapath
    // --------------------------------------------------
    // First bit goes out together with the load
    assign ctrl.tx_load   = (state_q == ST_LOAD);
    assign ctrl.first_en  = (state_q == ST_LOAD);
    assign ctrl.sample_en = rise;
    // No shift after the eighth bit
    assign ctrl.shift_en  = fall && (bit_cnt_q != 4'd7);
    assign ctrl.rx_push   = frame_end;
    assign ctrl.mosi_sel  = (state_q != ST_IDLE) && !frame_end;

    assign busy_o = (state_q != ST_IDLE);
    assign sclk_o = sclk_q;
    assign cs_n_o = cs_n_q;

endmodule

// ==== rtl/spi_ctrl_if.sv ====
// --------------------------------------------------
// Per-bit strobes from the SPI controller
// to the shift datapath
// --------------------------------------------------
`timescale 1ns/1ps

interface spi_ctrl_if;

    logic tx_load;
    logic first_en;
    logic shift_en;
    logic sample_en;
    logic mosi_sel;
    logic rx_push;

    modport ctrl (
        output tx_load, first_en, shift_en, sample_en, mosi_sel, rx_push
    );

    modport dp (
        input  tx_load, first_en, shift_en, sample_en, mosi_sel, rx_push
    );

endinterface

// ==== rtl/spi_datapath.sv ====
// --------------------------------------------------
// SPI shift datapath
// TX and RX shift registers, registered MOSI,
// byte FIFOs and watermark flags
// --------------------------------------------------
`timescale 1ns/1ps

module spi_datapath #(
    parameter int FIFO_ADDR_W = 3
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     miso_i,
    output logic                     mosi_o,
    spi_ctrl_if.dp                   dp,
    input  logic                     lsb_first_i,
    input  logic [FIFO_ADDR_W-1:0]   tx_mark_lvl_i,
    input  logic [FIFO_ADDR_W-1:0]   rx_mark_lvl_i,
    input  logic                     tx_push_i,
    input  spi_pkg::spi_byte_t       tx_byte_i,
    output logic                     tx_full_o,
    output logic                     tx_empty_o,
    output logic                     tx_mark_o,
    input  logic                     rx_pop_i,
    output spi_pkg::spi_byte_t       rx_byte_o,
    output logic                     rx_empty_o,
    output logic                     rx_mark_o
);

    spi_pkg::spi_byte_t     tx_head;
    spi_pkg::spi_byte_t     tx_src;
    spi_pkg::spi_byte_t     tx_shift_q;
    spi_pkg::spi_byte_t     tx_shift_next;
    spi_pkg::spi_byte_t     rx_shift_q;
    logic                   mosi_next;
    logic [FIFO_ADDR_W:0]   tx_count;
    logic [FIFO_ADDR_W:0]   rx_count;

    // --------------------------------------------------
    // MISO receive
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (dp.sample_en) begin
            if (lsb_first_i) begin
                rx_shift_q <= {miso_i, rx_shift_q[7:1]};
            end else begin
                rx_shift_q <= {rx_shift_q[6:0], miso_i};
            end
        end
    end

    // --------------------------------------------------
    // MOSI transmit
    // --------------------------------------------------
    // On load the FIFO head feeds the shifter directly
    assign tx_src = dp.tx_load ? tx_head : tx_shift_q;

    always_comb begin
        tx_shift_next = tx_src;
        mosi_next     = mosi_o;
        if (dp.first_en || dp.shift_en) begin
            if (lsb_first_i) begin
                tx_shift_next = {1'b0, tx_src[7:1]};
                mosi_next     = tx_src[0];
            end else begin
                tx_shift_next = {tx_src[6:0], 1'b0};
                mosi_next     = tx_src[7];
            end
        end
    end

    always_ff @(posedge clk) begin
        tx_shift_q <= tx_shift_next;
    end

    // Held low outside a frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mosi_o <= 1'b0;
        end else if (!dp.mosi_sel) begin
            mosi_o <= 1'b0;
        end else begin
            mosi_o <= mosi_next;
        end
    end

    // --------------------------------------------------
    // Watermarks with hysteresis, equal count holds
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_mark_o <= 1'b0;
            rx_mark_o <= 1'b0;
        end else begin
            if (tx_count < {1'b0, tx_mark_lvl_i}) begin
                tx_mark_o <= 1'b1;
            end else if (tx_count > {1'b0, tx_mark_lvl_i}) begin
                tx_mark_o <= 1'b0;
            end
            if (rx_count > {1'b0, rx_mark_lvl_i}) begin
                rx_mark_o <= 1'b1;
            end else if (rx_count < {1'b0, rx_mark_lvl_i}) begin
                rx_mark_o <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // FIFOs
    // --------------------------------------------------
    spi_fifo #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) tx_fifo_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_i    (tx_push_i),
        .data_i  (tx_byte_i),
        .rd_i    (dp.tx_load),
        .data_o  (tx_head),
        .count_o (tx_count),
        .full_o  (tx_full_o),
        .empty_o (tx_empty_o)
    );

    // Received bytes are lost when this one is full
    spi_fifo #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) rx_fifo_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_i    (dp.rx_push),
        .data_i  (rx_shift_q),
        .rd_i    (rx_pop_i),
        .data_o  (rx_byte_o),
        .count_o (rx_count),
        .full_o  (),
        .empty_o (rx_empty_o)
    );

endmodule

// ==== rtl/spi_fifo.sv ====
// --------------------------------------------------
// Byte FIFO, first word fall through
// Ignores writes when full and reads when empty
// --------------------------------------------------
`timescale 1ns/1ps

module spi_fifo #(
    parameter int FIFO_ADDR_W = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_i,
    input  spi_pkg::spi_byte_t     data_i,
    input  logic                   rd_i,
    output spi_pkg::spi_byte_t     data_o,
    output logic [FIFO_ADDR_W:0]   count_o,
    output logic                   full_o,
    output logic                   empty_o
);

    localparam int DEPTH = 2 ** FIFO_ADDR_W;

    spi_pkg::spi_byte_t     mem [DEPTH];
    logic [FIFO_ADDR_W-1:0] wr_ptr_q;
    logic [FIFO_ADDR_W-1:0] rd_ptr_q;
    logic [FIFO_ADDR_W:0]   count_q;
    logic                   do_wr;
    logic                   do_rd;

    assign do_wr = wr_i && !full_o;
    assign do_rd = rd_i && !empty_o;

    // Storage array
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    // Pointers wrap on their own at DEPTH
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign data_o  = mem[rd_ptr_q];
    assign count_o = count_q;
    // Count only reaches DEPTH when full
    assign full_o  = count_q[FIFO_ADDR_W];
    assign empty_o = (count_q == '0);

endmodule

// ==== rtl/spi_master_top.sv ====
// --------------------------------------------------
// SPI master top level
// Host registers, frame controller and datapath
// --------------------------------------------------
`timescale 1ns/1ps

module spi_master_top #(
    parameter int FIFO_ADDR_W = 3
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       reg_wr_i,
    input  logic       reg_rd_i,
    input  logic [2:0] reg_addr_i,
    input  logic [7:0] reg_wdata_i,
    output logic [7:0] reg_rdata_o,
    input  logic       miso_i,
    output logic       sclk_o,
    output logic       cs_n_o,
    output logic       mosi_o
);

    spi_pkg::spi_cfg_t    cfg;
    spi_pkg::spi_status_t status;
    spi_pkg::spi_byte_t   tx_byte;
    spi_pkg::spi_byte_t   rx_byte;
    logic [3:0]           tx_mark_lvl;
    logic [3:0]           rx_mark_lvl;
    logic                 tx_push;
    logic                 rx_pop;
    logic                 tx_full;
    logic                 tx_empty;
    logic                 rx_empty;
    logic                 tx_mark;
    logic                 rx_mark;
    logic                 busy;

    spi_ctrl_if ctrl_if ();

    assign status = '{busy: busy, rx_mark: rx_mark, tx_mark: tx_mark,
                      rx_empty: rx_empty, tx_empty: tx_empty, tx_full: tx_full};

    spi_reg_decode spi_reg_decode_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .reg_wr_i      (reg_wr_i),
        .reg_rd_i      (reg_rd_i),
        .reg_addr_i    (reg_addr_i),
        .reg_wdata_i   (reg_wdata_i),
        .reg_rdata_o   (reg_rdata_o),
        .cfg_o         (cfg),
        .tx_mark_lvl_o (tx_mark_lvl),
        .rx_mark_lvl_o (rx_mark_lvl),
        .tx_push_o     (tx_push),
        .tx_byte_o     (tx_byte),
        .rx_pop_o      (rx_pop),
        .status_i      (status),
        .rx_byte_i     (rx_byte)
    );

    spi_controller spi_controller_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_i      (cfg),
        .tx_empty_i (tx_empty),
        .busy_o     (busy),
        .sclk_o     (sclk_o),
        .cs_n_o     (cs_n_o),
        .ctrl       (ctrl_if.ctrl)
    );

    spi_datapath #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) spi_datapath_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .miso_i        (miso_i),
        .mosi_o        (mosi_o),
        .dp            (ctrl_if.dp),
        .lsb_first_i   (cfg.lsb_first),
        .tx_mark_lvl_i (tx_mark_lvl[FIFO_ADDR_W-1:0]),
        .rx_mark_lvl_i (rx_mark_lvl[FIFO_ADDR_W-1:0]),
        .tx_push_i     (tx_push),
        .tx_byte_i     (tx_byte),
        .tx_full_o     (tx_full),
        .tx_empty_o    (tx_empty),
        .tx_mark_o     (tx_mark),
        .rx_pop_i      (rx_pop),
        .rx_byte_o     (rx_byte),
        .rx_empty_o    (rx_empty),
        .rx_mark_o     (rx_mark)
    );

endmodule

// ==== rtl/spi_pkg.sv ====
// --------------------------------------------------
// SPI master shared definitions
// Register map, configuration and status records
// --------------------------------------------------
package spi_pkg;

    // Serial payload
    typedef logic [7:0] spi_byte_t;

    // Host register map
    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,
        REG_TXDATA = 3'd1,
        REG_RXDATA = 3'd2,
        REG_STATUS = 3'd3,
        REG_MARK   = 3'd4
    } spi_reg_e;

    // CTRL register contents, sclk half period is clk_div+1 cycles
    typedef struct packed {
        logic [3:0] clk_div;
        logic       lsb_first;
    } spi_cfg_t;

    // STATUS register, tx_full sits at bit 0
    typedef struct packed {
        logic busy;
        logic rx_mark;
        logic tx_mark;
        logic rx_empty;
        logic tx_empty;
        logic tx_full;
    } spi_status_t;

endpackage

// ==== rtl/spi_reg_decode.sv ====
// --------------------------------------------------
// Host register block
// Holds CTRL and MARK, turns TXDATA writes and RXDATA
// reads into FIFO strobes, muxes the read-back word
// --------------------------------------------------
`timescale 1ns/1ps

module spi_reg_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  reg_wr_i,
    input  logic                  reg_rd_i,
    input  logic [2:0]            reg_addr_i,
    input  logic [7:0]            reg_wdata_i,
    output logic [7:0]            reg_rdata_o,
    output spi_pkg::spi_cfg_t     cfg_o,
    output logic [3:0]            tx_mark_lvl_o,
    output logic [3:0]            rx_mark_lvl_o,
    output logic                  tx_push_o,
    output spi_pkg::spi_byte_t    tx_byte_o,
    output logic                  rx_pop_o,
    input  spi_pkg::spi_status_t  status_i,
    input  spi_pkg::spi_byte_t    rx_byte_i
);

    spi_pkg::spi_reg_e addr;
    spi_pkg::spi_cfg_t cfg_q;
    logic [7:0]        mark_q;

    assign addr = spi_pkg::spi_reg_e'(reg_addr_i);

    // --------------------------------------------------
    // Configuration registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q  <= '0;
            mark_q <= '0;
        end else if (reg_wr_i) begin
            if (addr == spi_pkg::REG_CTRL) begin
                cfg_q <= spi_pkg::spi_cfg_t'(reg_wdata_i[4:0]);
            end
            if (addr == spi_pkg::REG_MARK) begin
                mark_q <= reg_wdata_i;
            end
        end
    end

    assign cfg_o         = cfg_q;
    assign tx_mark_lvl_o = mark_q[3:0];
    assign rx_mark_lvl_o = mark_q[7:4];

    // FIFO strobes, the FIFOs themselves drop overflow and underflow
    assign tx_push_o = reg_wr_i && (addr == spi_pkg::REG_TXDATA);
    assign tx_byte_o = reg_wdata_i;
    assign rx_pop_o  = reg_rd_i && (addr == spi_pkg::REG_RXDATA);

    // --------------------------------------------------
    // Read-back multiplexer
    // --------------------------------------------------
    always_comb begin
        case (addr)
            spi_pkg::REG_CTRL:   reg_rdata_o = {3'b000, cfg_q};
            spi_pkg::REG_RXDATA: reg_rdata_o = rx_byte_i;
            spi_pkg::REG_STATUS: reg_rdata_o = {2'b00, status_i};
            spi_pkg::REG_MARK:   reg_rdata_o = mark_q;
            // TXDATA is write only
            default:             reg_rdata_o = 8'h00;
        endcase
    end

endmodule

// ==== verif/spi_master_assert.sv ====
// --------------------------------------------------
// SPI pin assertions, bound into the master top
// --------------------------------------------------
`timescale 1ns/1ps

module spi_master_assert (
    input logic clk,
    input logic rst_n,
    input logic sclk_o,
    input logic cs_n_o,
    input logic mosi_o
);

    // Mode 0, clock idles low outside a frame
    sclk_idle_low : assert property (@(posedge clk) disable iff (!rst_n)
        cs_n_o |-> !sclk_o)
        else $error("sclk high while cs_n is deasserted");

    // Slave samples on the rising edge
    mosi_stable_high : assert property (@(posedge clk) disable iff (!rst_n)
        sclk_o |-> $stable(mosi_o))
        else $error("mosi changed while sclk was high");

    cs_n_after_reset : assert property (@(posedge clk)
        $rose(rst_n) |-> cs_n_o)
        else $error("cs_n not high when reset released");

endmodule

bind spi_master_top spi_master_assert spi_master_assert_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .sclk_o (sclk_o),
    .cs_n_o (cs_n_o),
    .mosi_o (mosi_o)
);

// ==== verif/spi_master_tb.sv ====
// --------------------------------------------------
// SPI master loopback testbench
// Table-driven MOSI to MISO loopback through the
// host registers, plus FIFO depth and watermarks
// --------------------------------------------------
`timescale 1ns/1ps

module spi_master_tb;

    localparam int FIFO_ADDR_W = 3;
    localparam int DEPTH       = 2 ** FIFO_ADDR_W;
    localparam int NUM_ROWS    = 6;
    localparam int POLL_LIMIT  = 4000;

    typedef struct packed {
        logic [7:0] data;
        logic       use_rand;
        logic       lsb_first;
        logic [3:0] clk_div;
    } row_t;

    logic       clk;
    logic       rst_n;
    logic       reg_wr_i;
    logic       reg_rd_i;
    logic [2:0] reg_addr_i;
    logic [7:0] reg_wdata_i;
    logic [7:0] reg_rdata_o;
    logic       sclk_o;
    logic       cs_n_o;
    logic       mosi_o;

    row_t       stim_table [NUM_ROWS];
    logic [7:0] sent_q [$];
    logic [31:0] lfsr_q;
    logic [7:0] rd_data;
    logic [7:0] tx_data;
    int         checks;
    int         errors;

    // Pin monitor state
    int         frame_div;
    int         low_cycles;
    int         sclk_rises;
    int         frames_seen;
    logic       sclk_prev;
    logic       cs_n_prev;

    spi_master_top #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) spi_master_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr_i    (reg_wr_i),
        .reg_rd_i    (reg_rd_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .miso_i      (mosi_o),
        .sclk_o      (sclk_o),
        .cs_n_o      (cs_n_o),
        .mosi_o      (mosi_o)
    );

    always #10 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hD000_0001;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic next_random_byte(output logic [7:0] b);
        b = '0;
        repeat (8) begin
            lfsr_q = lfsr_step(lfsr_q);
            b = {b[6:0], lfsr_q[0]};
        end
    endtask

    // Expected STATUS from tx_full at bit 0 up to busy at bit 5
    function automatic logic [7:0] status_word(input logic tx_full, input logic tx_empty,
                                               input logic rx_empty, input logic tx_mark,
                                               input logic rx_mark, input logic busy);
        return {2'b00, busy, rx_mark, tx_mark, rx_empty, tx_empty, tx_full};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic reg_write(input logic [2:0] addr, input logic [7:0] data);
        @(negedge clk);
        reg_wr_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(negedge clk);
        reg_wr_i    = 1'b0;
    endtask

    // Data sampled mid low phase before the popping edge
    task automatic reg_read(input logic [2:0] addr, output logic [7:0] data);
        @(negedge clk);
        reg_rd_i   = 1'b1;
        reg_addr_i = addr;
        #5;
        data = reg_rdata_o;
        @(negedge clk);
        reg_rd_i   = 1'b0;
    endtask

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // Done when TX FIFO drained and no frame running
    task automatic wait_frames_done(input string what);
        logic [7:0] st;
        int         polls;
        logic       done;
        polls = 0;
        done  = 1'b0;
        while (!done && polls < POLL_LIMIT) begin
            reg_read(spi_pkg::REG_STATUS, st);
            done = st[1] && !st[5];
            polls++;
        end
        if (!done) begin
            $display("Timeout: frames never finished during %s", what);
            errors++;
            finish_run();
        end
    endtask

    task automatic fill_table();
        stim_table[0] = '{data: 8'hA5, use_rand: 1'b0, lsb_first: 1'b0, clk_div: 4'd0};
        stim_table[1] = '{data: 8'h3C, use_rand: 1'b0, lsb_first: 1'b0, clk_div: 4'd3};
        stim_table[2] = '{data: 8'h00, use_rand: 1'b1, lsb_first: 1'b0, clk_div: 4'd0};
        stim_table[3] = '{data: 8'h01, use_rand: 1'b0, lsb_first: 1'b1, clk_div: 4'd0};
        stim_table[4] = '{data: 8'h80, use_rand: 1'b0, lsb_first: 1'b1, clk_div: 4'd3};
        stim_table[5] = '{data: 8'h00, use_rand: 1'b1, lsb_first: 1'b1, clk_div: 4'd3};
    endtask

    // --------------------------------------------------
    // Frame shape on the SPI pins
    // --------------------------------------------------
    // Eight sclk pulses per frame and cs_n low for 16 half periods plus one
    always @(negedge clk) begin
        if (!cs_n_o) begin
            low_cycles++;
            if (sclk_o && !sclk_prev) begin
                sclk_rises++;
            end
        end else if (!cs_n_prev) begin
            frames_seen++;
            check_value("sclk rises in frame", sclk_rises, 8);
            check_value("cs_n low cycles", low_cycles, 16 * (frame_div + 1) + 1);
            low_cycles = 0;
            sclk_rises = 0;
        end
        sclk_prev = sclk_o;
        cs_n_prev = cs_n_o;
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        reg_wr_i    = 1'b0;
        reg_rd_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        lfsr_q      = 32'h69df_3583;
        checks      = 0;
        errors      = 0;
        frame_div   = 0;
        low_cycles  = 0;
        sclk_rises  = 0;
        frames_seen = 0;
        sclk_prev   = 1'b0;
        cs_n_prev   = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset values
        reg_read(spi_pkg::REG_STATUS, rd_data);
        check_value("STATUS after reset", rd_data, status_word(0, 1, 1, 0, 0, 0));
        reg_read(spi_pkg::REG_CTRL, rd_data);
        check_value("CTRL after reset", rd_data, 8'h00);
        reg_read(spi_pkg::REG_MARK, rd_data);
        check_value("MARK after reset", rd_data, 8'h00);

        // Loopback returns each byte unchanged in both bit orders
        fill_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            tx_data = stim_table[i].data;
            if (stim_table[i].use_rand) begin
                next_random_byte(tx_data);
            end
            reg_write(spi_pkg::REG_CTRL,
                      {3'b000, stim_table[i].clk_div, stim_table[i].lsb_first});
            frame_div = stim_table[i].clk_div;
            reg_read(spi_pkg::REG_CTRL, rd_data);
            check_value($sformatf("CTRL row %0d", i), rd_data,
                        {3'b000, stim_table[i].clk_div, stim_table[i].lsb_first});
            reg_write(spi_pkg::REG_TXDATA, tx_data);
            wait_frames_done($sformatf("table row %0d", i));
            reg_read(spi_pkg::REG_RXDATA, rd_data);
            check_value($sformatf("loopback byte row %0d", i), rd_data, tx_data);
            reg_read(spi_pkg::REG_STATUS, rd_data);
            check_value($sformatf("rx_empty row %0d", i), {7'b0, rd_data[2]}, 8'h01);
        end

        // Fill TX FIFO at the slowest clock while the first byte leaves at once
        reg_write(spi_pkg::REG_CTRL, {3'b000, 4'd15, 1'b0});
        frame_div = 15;
        for (int k = 0; k < DEPTH; k++) begin
            next_random_byte(tx_data);
            sent_q.push_back(tx_data);
            reg_write(spi_pkg::REG_TXDATA, tx_data);
        end
        reg_read(spi_pkg::REG_STATUS, rd_data);
        check_value("tx_full after filling", {7'b0, rd_data[0]}, 8'h00);
        check_value("busy after filling", {7'b0, rd_data[5]}, 8'h01);
        wait_frames_done("full FIFO burst");
        for (int k = 0; k < DEPTH; k++) begin
            reg_read(spi_pkg::REG_RXDATA, rd_data);
            check_value($sformatf("burst byte %0d", k), rd_data, sent_q.pop_front());
        end
        reg_read(spi_pkg::REG_STATUS, rd_data);
        check_value("rx_empty after burst", {7'b0, rd_data[2]}, 8'h01);

        // Watermarks with both levels at 2
        reg_write(spi_pkg::REG_CTRL, {3'b000, 4'd0, 1'b0});
        frame_div = 0;
        reg_write(spi_pkg::REG_MARK, 8'h22);
        for (int k = 0; k < 3; k++) begin
            next_random_byte(tx_data);
            sent_q.push_back(tx_data);
            reg_write(spi_pkg::REG_TXDATA, tx_data);
        end
        wait_frames_done("watermark frames");
        reg_read(spi_pkg::REG_STATUS, rd_data);
        check_value("STATUS with three bytes", rd_data, status_word(0, 1, 0, 1, 1, 0));
        for (int k = 0; k < 2; k++) begin
            reg_read(spi_pkg::REG_RXDATA, rd_data);
            check_value($sformatf("mark byte %0d", k), rd_data, sent_q.pop_front());
        end
        reg_read(spi_pkg::REG_STATUS, rd_data);
        check_value("STATUS with one byte", rd_data, status_word(0, 1, 0, 1, 0, 0));
        reg_read(spi_pkg::REG_RXDATA, rd_data);
        check_value("mark byte 2", rd_data, sent_q.pop_front());

        // One chip-select frame per byte written
        check_value("frames on cs_n", frames_seen, NUM_ROWS + DEPTH + 3);

        finish_run();
    end

endmodule
